/* csr_pkg.sv */
`default_nettype none

package csr_pkg;

    localparam int XLEN = 32;

    typedef enum logic [2:0] {
        OPT_NONE  = 3'd0,
        OPT_EINST = 3'd1,                        // ECALL, MRET, EBREAK.
        OPT_CSRRW = 3'd2,
        OPT_CSRRS = 3'd3,
        OPT_CSRRC = 3'd4
    } csr_opt_e;

    // Immediate field, either a system code or a CSR address.
    typedef union packed {
        logic [11:0] funct12;
        struct packed {
            logic [1:0] acc;                     // 11 is read-only.
            logic [1:0] priv;
            logic [7:0] index;
        } addr;
    } csr_word_u;

    localparam logic [11:0] FUNCT12_ECALL  = 12'h000;
    localparam logic [11:0] FUNCT12_EBREAK = 12'h001;
    localparam logic [11:0] FUNCT12_MRET   = 12'h302;

    // ****************************************
    localparam logic [11:0] CSR_MSTATUS   = 12'h300;
    localparam logic [11:0] CSR_MIE       = 12'h304;
    localparam logic [11:0] CSR_MTVEC     = 12'h305;
    localparam logic [11:0] CSR_MEPC      = 12'h341;
    localparam logic [11:0] CSR_MCAUSE    = 12'h342;
    localparam logic [11:0] CSR_MTIMECMP  = 12'h7C0;
    localparam logic [11:0] CSR_MTIMECMPH = 12'h7C1;
    localparam logic [11:0] CSR_MTIME     = 12'hBC0;
    localparam logic [11:0] CSR_MTIMEH    = 12'hBC1;

    localparam int MSTATUS_MIE    = 3;
    localparam int MSTATUS_MPIE   = 7;
    localparam int MSTATUS_MPP_HI = 12;
    localparam int MSTATUS_MPP_LO = 11;
    localparam logic [XLEN-1:0] MSTATUS_MASK = 32'h0000_1888;
    localparam int MIE_MTIE       = 7;

    localparam logic [XLEN-1:0] CAUSE_ECALL_M = 32'd11;
    localparam logic [XLEN-1:0] CAUSE_MTIMER  = 32'h8000_0007;

    localparam logic TRAP_ENTER = 1'b0;
    localparam logic TRAP_RET   = 1'b1;

endpackage

`default_nettype wire

/* csr_regfile.sv */
`default_nettype none

module csr_regfile (
    input  wire logic                      clk,
    input  wire logic                      rst_i,
    input  wire logic [11:0]               bus_addr_i,
    input  wire logic [csr_pkg::XLEN-1:0]  bus_wdata_i,
    input  wire logic                      bus_we_i,
    input  wire logic                      trap_we_i,
    input  wire logic                      trap_kind_i,
    input  wire logic [csr_pkg::XLEN-1:0]  trap_mepc_i,
    input  wire logic [csr_pkg::XLEN-1:0]  trap_mcause_i,
    output logic      [csr_pkg::XLEN-1:0]  rdata_o,
    output logic                           hit_o,
    output logic                           mstatus_mie_o,
    output logic                           mie_mtie_o,
    output logic      [csr_pkg::XLEN-1:0]  mtvec_o,
    output logic      [csr_pkg::XLEN-1:0]  mepc_o
);

    logic [csr_pkg::XLEN-1:0] mstatus_q;
    logic [csr_pkg::XLEN-1:0] mie_q;
    logic [csr_pkg::XLEN-1:0] mtvec_q;
    logic [csr_pkg::XLEN-1:0] mepc_q;
    logic [csr_pkg::XLEN-1:0] mcause_q;

    // ****************************************
    // Register update, trap before bus.
    always_ff @(posedge clk) begin
        if (rst_i) begin
            mstatus_q <= '0;
            mie_q     <= '0;
            mtvec_q   <= '0;
            mepc_q    <= '0;
            mcause_q  <= '0;
        end else if (trap_we_i) begin
            if (trap_kind_i == csr_pkg::TRAP_ENTER) begin
                mstatus_q[csr_pkg::MSTATUS_MPIE] <= mstatus_q[csr_pkg::MSTATUS_MIE];
                mstatus_q[csr_pkg::MSTATUS_MIE]  <= 1'b0;
                mstatus_q[csr_pkg::MSTATUS_MPP_HI:csr_pkg::MSTATUS_MPP_LO] <= 2'b11;
                mepc_q   <= trap_mepc_i;
                mcause_q <= trap_mcause_i;
            end else begin
                mstatus_q[csr_pkg::MSTATUS_MIE]  <= mstatus_q[csr_pkg::MSTATUS_MPIE];
                mstatus_q[csr_pkg::MSTATUS_MPIE] <= 1'b1;
                mstatus_q[csr_pkg::MSTATUS_MPP_HI:csr_pkg::MSTATUS_MPP_LO] <= 2'b00;
            end
        end else if (bus_we_i) begin
            case (bus_addr_i)
                csr_pkg::CSR_MSTATUS: mstatus_q <= bus_wdata_i & csr_pkg::MSTATUS_MASK;
                csr_pkg::CSR_MIE:     mie_q     <= bus_wdata_i;
                csr_pkg::CSR_MTVEC:   mtvec_q   <= bus_wdata_i;
                csr_pkg::CSR_MEPC:    mepc_q    <= bus_wdata_i;
                csr_pkg::CSR_MCAUSE:  mcause_q  <= bus_wdata_i;
                default: ;                       // Not in this block.
            endcase
        end
    end

    always_comb begin
        hit_o   = 1'b1;
        rdata_o = '0;
        case (bus_addr_i)
            csr_pkg::CSR_MSTATUS: rdata_o = mstatus_q;
            csr_pkg::CSR_MIE:     rdata_o = mie_q;
            csr_pkg::CSR_MTVEC:   rdata_o = mtvec_q;
            csr_pkg::CSR_MEPC:    rdata_o = mepc_q;
            csr_pkg::CSR_MCAUSE:  rdata_o = mcause_q;
            default:              hit_o   = 1'b0;
        endcase
    end

    assign mstatus_mie_o = mstatus_q[csr_pkg::MSTATUS_MIE];
    assign mie_mtie_o    = mie_q[csr_pkg::MIE_MTIE];
    assign mtvec_o       = mtvec_q;
    assign mepc_o        = mepc_q;

endmodule

`default_nettype wire

/* csr_exec.sv */
`default_nettype none

module csr_exec (
    input  wire logic                      clk,
    input  wire logic                      rst_i,
    input  wire logic                      valid_i,
    input  wire csr_pkg::csr_opt_e         opt_i,
    input  wire logic [csr_pkg::XLEN-1:0]  pc_i,
    input  wire csr_pkg::csr_word_u        imm_i,
    input  wire logic [4:0]                rs1_i,
    input  wire logic [csr_pkg::XLEN-1:0]  rs1_data_i,
    input  wire logic                      gnt_i,
    input  wire logic [csr_pkg::XLEN-1:0]  rdata_i,
    input  wire logic [csr_pkg::XLEN-1:0]  mtvec_i,
    input  wire logic [csr_pkg::XLEN-1:0]  mepc_i,
    output logic                           req_o,
    output logic      [11:0]               addr_o,
    output logic      [csr_pkg::XLEN-1:0]  wdata_o,
    output logic                           we_o,
    output logic                           trap_we_o,
    output logic                           trap_kind_o,
    output logic      [csr_pkg::XLEN-1:0]  trap_mepc_o,
    output logic      [csr_pkg::XLEN-1:0]  trap_mcause_o,
    output logic      [csr_pkg::XLEN-1:0]  rddata_o,
    output logic                           redirect_o,
    output logic      [csr_pkg::XLEN-1:0]  redirect_pc_o
);

    logic              csr_wr;
    logic              trap_req;
    logic              read_only;
    logic              rs1_zero;

    assign read_only = (imm_i.addr.acc == 2'b11);
    assign rs1_zero  = (rs1_i == 5'd0);

    // ****************************************
    // Decode and read-modify-write.
    always_comb begin
        csr_wr        = 1'b0;
        trap_req      = 1'b0;
        wdata_o       = '0;
        trap_kind_o   = csr_pkg::TRAP_ENTER;
        trap_mcause_o = '0;
        rddata_o      = '0;
        redirect_o    = 1'b0;
        redirect_pc_o = '0;
        if (valid_i) begin
            case (opt_i)
                csr_pkg::OPT_CSRRW: begin
                    rddata_o = rdata_i;
                    wdata_o  = rs1_data_i;
                    csr_wr   = !read_only;
                end
                csr_pkg::OPT_CSRRS: begin
                    rddata_o = rdata_i;
                    wdata_o  = rdata_i | rs1_data_i;
                    csr_wr   = !read_only && !rs1_zero;
                end
                csr_pkg::OPT_CSRRC: begin
                    rddata_o = rdata_i;
                    wdata_o  = rdata_i & ~rs1_data_i;
                    csr_wr   = !read_only && !rs1_zero;
                end
                csr_pkg::OPT_EINST: begin
                    case (imm_i.funct12)
                        csr_pkg::FUNCT12_ECALL: begin
                            trap_req      = 1'b1;
                            trap_mcause_o = csr_pkg::CAUSE_ECALL_M;
                            redirect_o    = 1'b1;
                            redirect_pc_o = mtvec_i;
                        end
                        csr_pkg::FUNCT12_MRET: begin
                            trap_req      = 1'b1;
                            trap_kind_o   = csr_pkg::TRAP_RET;
                            redirect_o    = 1'b1;
                            redirect_pc_o = mepc_i;
                        end
                        csr_pkg::FUNCT12_EBREAK: ;      // No effect.
                        default: ;
                    endcase
                end
                default: ;
            endcase
        end
    end

    assign req_o       = valid_i;
    assign addr_o      = imm_i.funct12;
    assign we_o        = gnt_i & csr_wr;
    assign trap_we_o   = gnt_i & trap_req;
    assign trap_mepc_o = pc_i;

endmodule

`default_nettype wire

/* clint_timer.sv */
`default_nettype none

module clint_timer #(
    parameter int TIMER_PRESCALE = 4
) (
    input  wire logic                      clk,
    input  wire logic                      rst_i,
    input  wire logic [11:0]               bus_addr_i,
    input  wire logic [csr_pkg::XLEN-1:0]  bus_wdata_i,
    input  wire logic                      bus_we_i,
    output logic      [csr_pkg::XLEN-1:0]  rdata_o,
    output logic                           hit_o,
    output logic                           pending_o
);

    localparam int PW = (TIMER_PRESCALE > 1) ? $clog2(TIMER_PRESCALE) : 1;

    logic [PW-1:0] presc_q;
    logic          tick;
    logic [63:0]   mtime_q;
    logic [63:0]   mtimecmp_q;

    assign tick = (presc_q == PW'(TIMER_PRESCALE - 1));

    always_ff @(posedge clk) begin
        if (rst_i) begin
            presc_q    <= '0;
            mtime_q    <= '0;
            mtimecmp_q <= '1;
            pending_o  <= 1'b0;
        end else begin
            presc_q <= tick ? '0 : presc_q + 1'b1;
            if (tick) begin
                mtime_q <= mtime_q + 64'd1;
            end
            if (bus_we_i && bus_addr_i == csr_pkg::CSR_MTIMECMP) begin
                mtimecmp_q[31:0] <= bus_wdata_i;
            end
            if (bus_we_i && bus_addr_i == csr_pkg::CSR_MTIMECMPH) begin
                mtimecmp_q[63:32] <= bus_wdata_i;
            end
            pending_o <= (mtime_q >= mtimecmp_q);   // One cycle behind.
        end
    end

    always_comb begin
        hit_o   = 1'b1;
        rdata_o = '0;
        case (bus_addr_i)
            csr_pkg::CSR_MTIME:     rdata_o = mtime_q[31:0];
            csr_pkg::CSR_MTIMEH:    rdata_o = mtime_q[63:32];
            csr_pkg::CSR_MTIMECMP:  rdata_o = mtimecmp_q[31:0];
            csr_pkg::CSR_MTIMECMPH: rdata_o = mtimecmp_q[63:32];
            default:                hit_o   = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* irq_ctrl.sv */
`default_nettype none

module irq_ctrl (
    input  wire logic                      clk,
    input  wire logic                      rst_i,
    input  wire logic                      pending_i,
    input  wire logic                      mstatus_mie_i,
    input  wire logic                      mie_mtie_i,
    input  wire logic [csr_pkg::XLEN-1:0]  pc_i,
    input  wire logic [csr_pkg::XLEN-1:0]  mtvec_i,
    input  wire logic                      gnt_i,
    output logic                           req_o,
    output logic                           trap_we_o,
    output logic      [csr_pkg::XLEN-1:0]  trap_mepc_o,
    output logic      [csr_pkg::XLEN-1:0]  trap_mcause_o,
    output logic                           redirect_o,
    output logic      [csr_pkg::XLEN-1:0]  redirect_pc_o
);

    logic taken_q;

    // Set for the cycle after a grant.
    always_ff @(posedge clk) begin
        if (rst_i) begin
            taken_q <= 1'b0;
        end else begin
            taken_q <= gnt_i;
        end
    end

    assign req_o         = pending_i & mstatus_mie_i & mie_mtie_i & ~taken_q;
    assign trap_we_o     = gnt_i;
    assign trap_mepc_o   = pc_i;                 // Pc of the next instruction.
    assign trap_mcause_o = csr_pkg::CAUSE_MTIMER;
    assign redirect_o    = gnt_i;
    assign redirect_pc_o = mtvec_i;

endmodule

`default_nettype wire

/* csr_bus_arbiter.sv */
`default_nettype none

module csr_bus_arbiter (
    input  wire logic                      req_exec_i,
    input  wire logic                      req_irq_i,
    input  wire logic [11:0]               exec_addr_i,
    input  wire logic [csr_pkg::XLEN-1:0]  exec_wdata_i,
    input  wire logic                      exec_we_i,
    input  wire logic                      exec_trap_we_i,
    input  wire logic                      exec_trap_kind_i,
    input  wire logic [csr_pkg::XLEN-1:0]  exec_trap_mepc_i,
    input  wire logic [csr_pkg::XLEN-1:0]  exec_trap_mcause_i,
    input  wire logic                      exec_redirect_i,
    input  wire logic [csr_pkg::XLEN-1:0]  exec_redirect_pc_i,
    input  wire logic                      irq_trap_we_i,
    input  wire logic [csr_pkg::XLEN-1:0]  irq_trap_mepc_i,
    input  wire logic [csr_pkg::XLEN-1:0]  irq_trap_mcause_i,
    input  wire logic                      irq_redirect_i,
    input  wire logic [csr_pkg::XLEN-1:0]  irq_redirect_pc_i,
    output logic                           gnt_exec_o,
    output logic                           gnt_irq_o,
    output logic      [11:0]               bus_addr_o,
    output logic      [csr_pkg::XLEN-1:0]  bus_wdata_o,
    output logic                           bus_we_o,
    output logic                           trap_we_o,
    output logic                           trap_kind_o,
    output logic      [csr_pkg::XLEN-1:0]  trap_mepc_o,
    output logic      [csr_pkg::XLEN-1:0]  trap_mcause_o,
    output logic                           redirect_o,
    output logic      [csr_pkg::XLEN-1:0]  redirect_pc_o
);

    assign gnt_exec_o = req_exec_i;              // Exec always wins.
    assign gnt_irq_o  = req_irq_i & ~req_exec_i;

    // Only exec drives the data bus.
    assign bus_addr_o  = exec_addr_i;
    assign bus_wdata_o = exec_wdata_i;
    assign bus_we_o    = gnt_exec_o & exec_we_i;

    // ****************************************
    assign trap_we_o     = gnt_exec_o ? exec_trap_we_i : (gnt_irq_o & irq_trap_we_i);
    assign trap_kind_o   = gnt_exec_o ? exec_trap_kind_i : csr_pkg::TRAP_ENTER;
    assign trap_mepc_o   = gnt_exec_o ? exec_trap_mepc_i : irq_trap_mepc_i;
    assign trap_mcause_o = gnt_exec_o ? exec_trap_mcause_i : irq_trap_mcause_i;
    assign redirect_o    = gnt_exec_o ? exec_redirect_i : (gnt_irq_o & irq_redirect_i);
    assign redirect_pc_o = gnt_exec_o ? exec_redirect_pc_i : irq_redirect_pc_i;

endmodule

`default_nettype wire

/* csr_clint_top.sv */
`default_nettype none

module csr_clint_top #(
    parameter int TIMER_PRESCALE = 4
) (
    input  wire logic                      clk,
    input  wire logic                      rst_i,
    input  wire logic                      valid_i,
    input  wire csr_pkg::csr_opt_e         opt_i,
    input  wire logic [csr_pkg::XLEN-1:0]  pc_i,
    input  wire csr_pkg::csr_word_u        imm_i,
    input  wire logic [4:0]                rs1_i,
    input  wire logic [csr_pkg::XLEN-1:0]  rs1_data_i,
    output logic      [csr_pkg::XLEN-1:0]  csr_rddata_o,
    output logic                           redirect_o,
    output logic      [csr_pkg::XLEN-1:0]  redirect_pc_o,
    output logic                           irq_pending_o
);

    // ****************************************
    logic [11:0]              bus_addr;
    logic [csr_pkg::XLEN-1:0] bus_wdata;
    logic                     bus_we;
    logic [csr_pkg::XLEN-1:0] bus_rdata;
    logic                     trap_we;
    logic                     trap_kind;
    logic [csr_pkg::XLEN-1:0] trap_mepc;
    logic [csr_pkg::XLEN-1:0] trap_mcause;

    logic [csr_pkg::XLEN-1:0] rf_rdata;
    logic                     rf_hit;
    logic [csr_pkg::XLEN-1:0] tmr_rdata;
    logic                     tmr_hit;
    logic                     mstatus_mie;
    logic                     mie_mtie;
    logic [csr_pkg::XLEN-1:0] mtvec;
    logic [csr_pkg::XLEN-1:0] mepc;

    logic                     ex_req;
    logic                     ex_gnt;
    logic [11:0]              ex_addr;
    logic [csr_pkg::XLEN-1:0] ex_wdata;
    logic                     ex_we;
    logic                     ex_trap_we;
    logic                     ex_trap_kind;
    logic [csr_pkg::XLEN-1:0] ex_trap_mepc;
    logic [csr_pkg::XLEN-1:0] ex_trap_mcause;
    logic                     ex_redirect;
    logic [csr_pkg::XLEN-1:0] ex_redirect_pc;

    logic                     irq_req;
    logic                     irq_gnt;
    logic                     irq_trap_we;
    logic [csr_pkg::XLEN-1:0] irq_trap_mepc;
    logic [csr_pkg::XLEN-1:0] irq_trap_mcause;
    logic                     irq_redirect;
    logic [csr_pkg::XLEN-1:0] irq_redirect_pc;

    assign bus_rdata = rf_hit ? rf_rdata : (tmr_hit ? tmr_rdata : '0);

    csr_exec u_exec (
        .clk(clk), .rst_i(rst_i), .valid_i(valid_i), .opt_i(opt_i), .pc_i(pc_i),
        .imm_i(imm_i), .rs1_i(rs1_i), .rs1_data_i(rs1_data_i), .gnt_i(ex_gnt),
        .rdata_i(bus_rdata), .mtvec_i(mtvec), .mepc_i(mepc), .req_o(ex_req),
        .addr_o(ex_addr), .wdata_o(ex_wdata), .we_o(ex_we), .trap_we_o(ex_trap_we),
        .trap_kind_o(ex_trap_kind), .trap_mepc_o(ex_trap_mepc),
        .trap_mcause_o(ex_trap_mcause), .rddata_o(csr_rddata_o),
        .redirect_o(ex_redirect), .redirect_pc_o(ex_redirect_pc)
    );

    irq_ctrl u_irq (
        .clk(clk), .rst_i(rst_i), .pending_i(irq_pending_o),
        .mstatus_mie_i(mstatus_mie), .mie_mtie_i(mie_mtie), .pc_i(pc_i),
        .mtvec_i(mtvec), .gnt_i(irq_gnt), .req_o(irq_req), .trap_we_o(irq_trap_we),
        .trap_mepc_o(irq_trap_mepc), .trap_mcause_o(irq_trap_mcause),
        .redirect_o(irq_redirect), .redirect_pc_o(irq_redirect_pc)
    );

    csr_bus_arbiter u_arb (
        .req_exec_i(ex_req), .req_irq_i(irq_req), .exec_addr_i(ex_addr),
        .exec_wdata_i(ex_wdata), .exec_we_i(ex_we), .exec_trap_we_i(ex_trap_we),
        .exec_trap_kind_i(ex_trap_kind), .exec_trap_mepc_i(ex_trap_mepc),
        .exec_trap_mcause_i(ex_trap_mcause), .exec_redirect_i(ex_redirect),
        .exec_redirect_pc_i(ex_redirect_pc), .irq_trap_we_i(irq_trap_we),
        .irq_trap_mepc_i(irq_trap_mepc), .irq_trap_mcause_i(irq_trap_mcause),
        .irq_redirect_i(irq_redirect), .irq_redirect_pc_i(irq_redirect_pc),
        .gnt_exec_o(ex_gnt), .gnt_irq_o(irq_gnt), .bus_addr_o(bus_addr),
        .bus_wdata_o(bus_wdata), .bus_we_o(bus_we), .trap_we_o(trap_we),
        .trap_kind_o(trap_kind), .trap_mepc_o(trap_mepc),
        .trap_mcause_o(trap_mcause), .redirect_o(redirect_o),
        .redirect_pc_o(redirect_pc_o)
    );

    csr_regfile u_regfile (
        .clk(clk), .rst_i(rst_i), .bus_addr_i(bus_addr), .bus_wdata_i(bus_wdata),
        .bus_we_i(bus_we), .trap_we_i(trap_we), .trap_kind_i(trap_kind),
        .trap_mepc_i(trap_mepc), .trap_mcause_i(trap_mcause), .rdata_o(rf_rdata),
        .hit_o(rf_hit), .mstatus_mie_o(mstatus_mie), .mie_mtie_o(mie_mtie),
        .mtvec_o(mtvec), .mepc_o(mepc)
    );

    clint_timer #(
        .TIMER_PRESCALE(TIMER_PRESCALE)
    ) u_timer (
        .clk(clk), .rst_i(rst_i), .bus_addr_i(bus_addr), .bus_wdata_i(bus_wdata),
        .bus_we_i(bus_we), .rdata_o(tmr_rdata), .hit_o(tmr_hit),
        .pending_o(irq_pending_o)
    );

endmodule

`default_nettype wire

/* csr_clint_chk.sv */
`default_nettype none

module csr_clint_chk (
    input wire logic clk,
    input wire logic rst_i,
    input wire logic req_exec_i,
    input wire logic gnt_exec_i,
    input wire logic gnt_irq_i,
    input wire logic trap_we_i,
    input wire logic bus_we_i
);

    timeunit 1ns;
    timeprecision 1ps;

    // ****************************************
    grant_one_hot: assert property (@(posedge clk) !(gnt_exec_i && gnt_irq_i))
        else $error("exec and irq grants are high together");

    // An interrupt grant may only start on a cycle without an instruction.
    irq_yields_to_exec: assert property (
        @(posedge clk) disable iff (rst_i) $rose(gnt_irq_i) |-> !req_exec_i)
        else $error("irq grant rose while exec was requesting");

    quiet_in_reset: assert property (@(posedge clk) rst_i |-> (!trap_we_i && !bus_we_i))
        else $error("CSR write strobe seen during reset");

endmodule

`default_nettype wire

/* tb_csr_clint.sv */
`default_nettype none

module tb_csr_clint;

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] MSTATUS_BITS = (32'd1 << 3) | (32'd1 << 7) | (32'd3 << 11);
    localparam logic [31:0] IRQ_PC       = 32'h0000_4000;

    logic                     clk = 1'b0;
    logic                     rst_i;
    logic                     valid_i;
    csr_pkg::csr_opt_e        opt_i;
    logic [31:0]              pc_i;
    csr_pkg::csr_word_u       imm_i;
    logic [4:0]               rs1_i;
    logic [31:0]              rs1_data_i;
    logic [csr_pkg::XLEN-1:0] csr_rddata_o;
    logic                     redirect_o;
    logic [csr_pkg::XLEN-1:0] redirect_pc_o;
    logic                     irq_pending_o;

    // Reference model state and expectations for the current cycle.
    logic [31:0] m_mstatus, m_mie, m_mtvec, m_mepc, m_mcause;
    logic [63:0] m_mtimecmp;
    logic        exp_chk_data;
    logic [31:0] exp_rd;
    logic        exp_redir;
    logic [31:0] exp_pc;
    logic [31:0] cur_pc;
    integer      seed = 32'h102c;

    always #5 clk = ~clk;

    csr_clint_top #(.TIMER_PRESCALE(2)) DUT (
        .clk(clk), .rst_i(rst_i), .valid_i(valid_i), .opt_i(opt_i), .pc_i(pc_i),
        .imm_i(imm_i), .rs1_i(rs1_i), .rs1_data_i(rs1_data_i),
        .csr_rddata_o(csr_rddata_o), .redirect_o(redirect_o),
        .redirect_pc_o(redirect_pc_o), .irq_pending_o(irq_pending_o)
    );

    bind csr_bus_arbiter csr_clint_chk u_chk (
        .clk(tb_csr_clint.clk), .rst_i(tb_csr_clint.rst_i), .req_exec_i(req_exec_i),
        .gnt_exec_i(gnt_exec_o), .gnt_irq_i(gnt_irq_o), .trap_we_i(trap_we_o),
        .bus_we_i(bus_we_o)
    );

    // ****************************************
    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_data(input string name, input logic [csr_pkg::XLEN-1:0] got,
                              input logic [csr_pkg::XLEN-1:0] exp);
        if (got !== exp)
            stop_on_error($sformatf("[ERROR] %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_redirect(input logic got_v, input logic [csr_pkg::XLEN-1:0] got_pc,
                                  input logic exp_v, input logic [csr_pkg::XLEN-1:0] exp_pc);
        if (got_v !== exp_v)
            stop_on_error($sformatf("[ERROR] redirect_o got 0x%h expected 0x%h", got_v, exp_v));
        if (exp_v && got_pc !== exp_pc)
            stop_on_error($sformatf("[ERROR] redirect_pc_o got 0x%h expected 0x%h",
                                    got_pc, exp_pc));
    endtask

    function automatic logic [31:0] model_read(input logic [11:0] addr);
        case (addr)
            csr_pkg::CSR_MSTATUS:   return m_mstatus;
            csr_pkg::CSR_MIE:       return m_mie;
            csr_pkg::CSR_MTVEC:     return m_mtvec;
            csr_pkg::CSR_MEPC:      return m_mepc;
            csr_pkg::CSR_MCAUSE:    return m_mcause;
            csr_pkg::CSR_MTIMECMP:  return m_mtimecmp[31:0];
            csr_pkg::CSR_MTIMECMPH: return m_mtimecmp[63:32];
            default:                return 32'd0;  // Unmapped, or mtime.
        endcase
    endfunction

    task automatic model_write(input logic [11:0] addr, input logic [31:0] val);
        case (addr)
            csr_pkg::CSR_MSTATUS:   m_mstatus = val & MSTATUS_BITS;
            csr_pkg::CSR_MIE:       m_mie = val;
            csr_pkg::CSR_MTVEC:     m_mtvec = val;
            csr_pkg::CSR_MEPC:      m_mepc = val;
            csr_pkg::CSR_MCAUSE:    m_mcause = val;
            csr_pkg::CSR_MTIMECMP:  m_mtimecmp[31:0] = val;
            csr_pkg::CSR_MTIMECMPH: m_mtimecmp[63:32] = val;
            default: ;                                 // mtime has no write path.
        endcase
    endtask

    task automatic trap_enter(input logic [31:0] epc, input logic [31:0] cause);
        m_mstatus[7]     = m_mstatus[3];
        m_mstatus[3]     = 1'b0;
        m_mstatus[12:11] = 2'b11;
        m_mepc           = epc;
        m_mcause         = cause;
    endtask

    task automatic trap_return();
        m_mstatus[3]     = m_mstatus[7];
        m_mstatus[7]     = 1'b1;
        m_mstatus[12:11] = 2'b00;
    endtask

    // Old value, write enable and new value of one CSR instruction.
    function automatic void ref_csr(input csr_pkg::csr_opt_e opt, input logic [11:0] addr,
                                    input logic [4:0] rs1, input logic [31:0] data,
                                    output logic [31:0] rd, output logic wr,
                                    output logic [31:0] nv);
        rd = model_read(addr);
        wr = 1'b0;
        nv = rd;
        case (opt)
            csr_pkg::OPT_CSRRW: begin
                nv = data;
                wr = (addr[11:10] != 2'b11);
            end
            csr_pkg::OPT_CSRRS: begin
                nv = rd | data;
                wr = (addr[11:10] != 2'b11) && (rs1 != 5'd0);
            end
            csr_pkg::OPT_CSRRC: begin
                nv = rd & ~data;
                wr = (addr[11:10] != 2'b11) && (rs1 != 5'd0);
            end
            default: rd = 32'd0;
        endcase
    endfunction

    task automatic issue(input csr_pkg::csr_opt_e opt, input logic [11:0] imm,
                         input logic [4:0] rs1, input logic [31:0] data, input logic chk);
        logic [31:0] rd;
        logic        wr;
        logic [31:0] nv;
        @(posedge clk);
        valid_i    <= 1'b1;
        opt_i      <= opt;
        pc_i       <= cur_pc;
        imm_i      <= imm;
        rs1_i      <= rs1;
        rs1_data_i <= data;
        ref_csr(opt, imm, rs1, data, rd, wr, nv);
        exp_chk_data = chk;
        exp_rd       = rd;
        exp_redir    = 1'b0;
        exp_pc       = 32'd0;
        if (opt == csr_pkg::OPT_EINST && imm == 12'h000) begin
            exp_redir = 1'b1;
            exp_pc    = m_mtvec;
            trap_enter(cur_pc, 32'd11);
        end else if (opt == csr_pkg::OPT_EINST && imm == 12'h302) begin
            exp_redir = 1'b1;
            exp_pc    = m_mepc;
            trap_return();
        end else if (wr) begin
            model_write(imm, nv);
        end
        cur_pc = cur_pc + 32'd4;
    endtask

    task automatic read_raw(input logic [11:0] addr, output logic [31:0] val);
        issue(csr_pkg::OPT_CSRRS, addr, 5'd0, 32'd0, 1'b0);
        @(negedge clk);
        val = csr_rddata_o;
    endtask

    task automatic idle_with_pc(input logic [31:0] pc);
        @(posedge clk);
        valid_i <= 1'b0;
        opt_i   <= csr_pkg::OPT_NONE;
        pc_i    <= pc;
    endtask

    // Outputs are stable by the falling edge.
    always @(negedge clk) begin
        if (!rst_i && valid_i) begin
            if (exp_chk_data)
                check_data("csr_rddata_o", csr_rddata_o, exp_rd);
            check_redirect(redirect_o, redirect_pc_o, exp_redir, exp_pc);
        end
    end

    // ****************************************
    initial begin
        logic [31:0]       r;
        logic [31:0]       t0;
        logic [31:0]       t1;
        logic [11:0]       addr;
        logic [4:0]        rs1;
        csr_pkg::csr_opt_e opt;
        logic              got;
        int                i;
        rst_i = 1'b1;
        valid_i = 1'b0;
        opt_i = csr_pkg::OPT_NONE;
        pc_i = 32'd0;
        imm_i = '0;
        rs1_i = 5'd0;
        rs1_data_i = 32'd0;
        {m_mstatus, m_mie, m_mtvec, m_mepc, m_mcause} = '0;
        m_mtimecmp = '1;
        {exp_chk_data, exp_rd, exp_redir, exp_pc} = '0;
        cur_pc = 32'h0000_0100;
        repeat (10) @(posedge clk);
        rst_i <= 1'b0;

        @(negedge clk);
        check_data("irq_pending_o", {31'd0, irq_pending_o}, 32'd0);
        check_redirect(redirect_o, redirect_pc_o, 1'b0, 32'd0);
        issue(csr_pkg::OPT_CSRRS, csr_pkg::CSR_MSTATUS, 5'd0, 32'd0, 1'b1);
        issue(csr_pkg::OPT_CSRRS, csr_pkg::CSR_MIE, 5'd0, 32'd0, 1'b1);
        issue(csr_pkg::OPT_CSRRS, csr_pkg::CSR_MTVEC, 5'd0, 32'd0, 1'b1);
        issue(csr_pkg::OPT_CSRRS, csr_pkg::CSR_MEPC, 5'd0, 32'd0, 1'b1);
        issue(csr_pkg::OPT_CSRRS, csr_pkg::CSR_MCAUSE, 5'd0, 32'd0, 1'b1);
        issue(csr_pkg::OPT_CSRRS, csr_pkg::CSR_MTIMECMP, 5'd0, 32'd0, 1'b1);
        issue(csr_pkg::OPT_CSRRS, csr_pkg::CSR_MTIMECMPH, 5'd0, 32'd0, 1'b1);

        for (i = 0; i < 40; i++) begin
            r = $random(seed);
            case (r[1:0])
                2'd0:    addr = csr_pkg::CSR_MTVEC;
                2'd1:    addr = csr_pkg::CSR_MEPC;
                default: addr = csr_pkg::CSR_MIE;
            endcase
            case (r[3:2])
                2'd0:    opt = csr_pkg::OPT_CSRRW;
                2'd1:    opt = csr_pkg::OPT_CSRRS;
                default: opt = csr_pkg::OPT_CSRRC;
            endcase
            rs1 = (r[6:4] == 3'd0) ? 5'd0 : {r[11:8], 1'b1};
            t0 = $random(seed);
            issue(opt, addr, rs1, t0, 1'b1);
        end
        issue(csr_pkg::OPT_CSRRS, csr_pkg::CSR_MTVEC, 5'd0, 32'hFFFF_FFFF, 1'b1);
        issue(csr_pkg::OPT_CSRRC, csr_pkg::CSR_MTVEC, 5'd0, 32'hFFFF_FFFF, 1'b1);
        issue(csr_pkg::OPT_CSRRS, csr_pkg::CSR_MTVEC, 5'd0, 32'd0, 1'b1);

        read_raw(csr_pkg::CSR_MTIME, t0);
        issue(csr_pkg::OPT_CSRRW, csr_pkg::CSR_MTIME, 5'd4, 32'hDEAD_0000, 1'b0);
        read_raw(csr_pkg::CSR_MTIME, t1);
        if (t1 < t0 || t1 - t0 > 32'd64)
            stop_on_error($sformatf("mtime moved from 0x%h to 0x%h, not a steady count",
                                    t0, t1));

        // ECALL with MIE set, then MRET.
        issue(csr_pkg::OPT_CSRRS, csr_pkg::CSR_MSTATUS, 5'd2, 32'h0000_0008, 1'b1);
        issue(csr_pkg::OPT_EINST, 12'h000, 5'd0, 32'd0, 1'b1);
        issue(csr_pkg::OPT_CSRRS, csr_pkg::CSR_MEPC, 5'd0, 32'd0, 1'b1);
        issue(csr_pkg::OPT_CSRRS, csr_pkg::CSR_MCAUSE, 5'd0, 32'd0, 1'b1);
        issue(csr_pkg::OPT_CSRRS, csr_pkg::CSR_MSTATUS, 5'd0, 32'd0, 1'b1);
        issue(csr_pkg::OPT_EINST, 12'h302, 5'd0, 32'd0, 1'b1);
        issue(csr_pkg::OPT_CSRRS, csr_pkg::CSR_MSTATUS, 5'd0, 32'd0, 1'b1);
        issue(csr_pkg::OPT_EINST, 12'h001, 5'd0, 32'd0, 1'b1);

        // ****************************************
        issue(csr_pkg::OPT_CSRRC, csr_pkg::CSR_MSTATUS, 5'd3, 32'h0000_0008, 1'b1);
        issue(csr_pkg::OPT_CSRRW, csr_pkg::CSR_MTVEC, 5'd1, 32'h0000_0800, 1'b1);
        read_raw(csr_pkg::CSR_MTIME, t0);
        issue(csr_pkg::OPT_CSRRW, csr_pkg::CSR_MTIMECMP, 5'd2, t0 + 32'd16, 1'b1);
        issue(csr_pkg::OPT_CSRRW, csr_pkg::CSR_MTIMECMPH, 5'd2, 32'd0, 1'b1);
        issue(csr_pkg::OPT_CSRRS, csr_pkg::CSR_MIE, 5'd3, 32'h0000_0080, 1'b1);
        issue(csr_pkg::OPT_CSRRS, csr_pkg::CSR_MSTATUS, 5'd3, 32'h0000_0008, 1'b1);
        idle_with_pc(IRQ_PC);
        got = 1'b0;
        for (i = 0; i < 200 && !got; i++) begin
            @(negedge clk);
            if (i == 0)
                check_data("irq_pending_o", {31'd0, irq_pending_o}, 32'd0);
            got = redirect_o;
        end
        if (!got)
            stop_on_error("timer interrupt never arrived");
        check_data("irq_pending_o", {31'd0, irq_pending_o}, 32'd1);
        check_redirect(redirect_o, redirect_pc_o, 1'b1, m_mtvec);
        trap_enter(IRQ_PC, 32'h8000_0007);
        for (i = 0; i < 20; i++) begin
            @(negedge clk);
            check_redirect(redirect_o, redirect_pc_o, 1'b0, 32'd0);
        end
        issue(csr_pkg::OPT_CSRRS, csr_pkg::CSR_MCAUSE, 5'd0, 32'd0, 1'b1);
        issue(csr_pkg::OPT_CSRRS, csr_pkg::CSR_MEPC, 5'd0, 32'd0, 1'b1);
        issue(csr_pkg::OPT_CSRRS, csr_pkg::CSR_MSTATUS, 5'd0, 32'd0, 1'b1);
        idle_with_pc(IRQ_PC);
        @(negedge clk);
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
csr_pkg.sv
csr_regfile.sv
csr_exec.sv
clint_timer.sv
irq_ctrl.sv
csr_bus_arbiter.sv
csr_clint_top.sv
csr_clint_chk.sv
tb_csr_clint.sv

/* Makefile */
TOP := tb_csr_clint

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f src.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP)

clean:
	rm -rf obj_dir
